// File: Makefile
# Verilator flow for the execute-stage testbench
TOP := exe_stage_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	-./obj_dir/sim_$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -qF '*** FAILED ***' sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -qF '*** PASSED ***' sim.log; then echo "Simulation ended without a verdict"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: hdl/exe_stage.sv
// RV32IM execute stage with operand select, ALU and mul/div units, and valid/ready output register
`default_nettype none
`timescale 1ns/100ps
`include "rv_exe_cfg.svh"

module exe_stage
  import rv_exe_pkg::*;
(
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           in_valid_i,
  output logic                          in_ready_o,
  input  exe_op_e                       op_i,
  input  wire                           use_imm_i,
  input  wire                           link_pc4_i,
  input  wire [`DATA_WIDTH-1:0]         rs1_i,
  input  wire [`DATA_WIDTH-1:0]         rs2_i,
  input  wire [`DATA_WIDTH-1:0]         imm_i,
  input  wire [`DATA_WIDTH-1:0]         pc4_i,
  input  wire [`DATA_WIDTH-1:0]         brj_pc_i,
  input  store_op_e                     store_op_i,
  input  load_op_e                      load_op_i,
  input  target_e                       target_i,
  input  wire [`REG_ADDR_WIDTH-1:0]     waddr_i,
  input  wire                           regfile_wr_i,
  input  wire                           data_wr_i,
  input  wire                           data_rd_i,
  input  wire [`MEM_TRANSFER_WIDTH-1:0] data_be_i,
  output logic                          out_valid_o,
  input  wire                           out_ready_i,
  output logic [`REG_ADDR_WIDTH-1:0]    m_regfile_waddr_o,
  output logic [`DATA_WIDTH-1:0]        m_rd_data_o,
  output logic                          m_regfile_wr_o,
  output logic [`DATA_WIDTH-1:0]        m_data_addr_o,
  output logic                          m_data_wr_o,
  output logic                          m_data_rd_o,
  output logic [`MEM_TRANSFER_WIDTH-1:0] m_data_be_o,
  output load_op_e                      m_load_op_o
);

  logic [`DATA_WIDTH-1:0] op_b;
  logic [`DATA_WIDTH-1:0] alu_result;
  logic [`DATA_WIDTH-1:0] md_result;
  logic                   md_start, md_busy, md_done;
  logic                   accept, load_out;
  logic [`DATA_WIDTH-1:0] st_data, link_val;

  // Side fields of an M op, parked here while the unit iterates
  logic [`REG_ADDR_WIDTH-1:0]     lat_waddr;
  logic                           lat_rf_wr, lat_data_wr, lat_data_rd;
  logic [`MEM_TRANSFER_WIDTH-1:0] lat_be;
  load_op_e                       lat_load_op;
  target_e                        lat_target;
  logic [`DATA_WIDTH-1:0]         lat_st_data, lat_link;

  // Values headed for the output register, from the inputs or the parked M op
  logic [`DATA_WIDTH-1:0]         sel_result, sel_st_data, sel_link, sel_rd_data;
  target_e                        sel_target;

  assign op_b = use_imm_i ? imm_i : rs2_i;

  // One result may sit in the output register and only one M op runs at a time
  assign in_ready_o = !md_busy && !md_done && (!out_valid_o || out_ready_i);
  assign accept     = in_valid_i && in_ready_o;
  assign md_start   = accept && op_i[4];
  assign load_out   = md_done || (accept && !op_i[4]);

  int_alu u_int_alu (
    .op_i     (alu_op_e'(op_i[3:0])),
    .a_i      (rs1_i),
    .b_i      (op_b),
    .result_o (alu_result)
  );

  mul_div_unit u_mul_div_unit (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (md_start),
    .op_i     (md_op_e'(op_i[2:0])),
    .a_i      (rs1_i),
    .b_i      (op_b),
    .result_o (md_result),
    .busy_o   (md_busy),
    .done_o   (md_done)
  );

  always_comb
  begin
    case (store_op_i)
      ST_SB:   st_data = {{(`DATA_WIDTH-8){1'b0}}, rs2_i[7:0]};
      ST_SH:   st_data = {{(`DATA_WIDTH-16){1'b0}}, rs2_i[15:0]};
      ST_SW:   st_data = rs2_i;
      default: st_data = '0;
    endcase
  end

  assign link_val = link_pc4_i ? pc4_i : brj_pc_i;  // jal/jalr link or the jump target

  always_ff @(posedge clk)
  begin
    if (md_start)
    begin
      lat_waddr   <= waddr_i;
      lat_rf_wr   <= regfile_wr_i;
      lat_data_wr <= data_wr_i;
      lat_data_rd <= data_rd_i;
      lat_be      <= data_be_i;
      lat_load_op <= load_op_i;
      lat_target  <= target_i;
      lat_st_data <= st_data;
      lat_link    <= link_val;
    end
  end

  assign sel_result  = md_done ? md_result : alu_result;
  assign sel_target  = md_done ? lat_target : target_i;
  assign sel_st_data = md_done ? lat_st_data : st_data;
  assign sel_link    = md_done ? lat_link : link_val;

  always_comb
  begin
    case (sel_target)
      TGT_ALU:   sel_rd_data = sel_result;
      TGT_STORE: sel_rd_data = sel_st_data;
      TGT_ZERO:  sel_rd_data = '0;
      default:   sel_rd_data = sel_link;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_valid_o    <= 1'b0;
      m_regfile_wr_o <= 1'b0;
      m_data_wr_o    <= 1'b0;
      m_data_rd_o    <= 1'b0;
    end
    else if (load_out)
    begin
      out_valid_o    <= 1'b1;
      m_regfile_wr_o <= md_done ? lat_rf_wr : regfile_wr_i;
      m_data_wr_o    <= md_done ? lat_data_wr : data_wr_i;
      m_data_rd_o    <= md_done ? lat_data_rd : data_rd_i;
    end
    else if (out_ready_i)
      out_valid_o <= 1'b0;  // Drained with nothing new behind it
  end

  always_ff @(posedge clk)
  begin
    if (load_out)
    begin
      m_regfile_waddr_o <= md_done ? lat_waddr : waddr_i;
      m_rd_data_o       <= sel_rd_data;
      m_data_addr_o     <= sel_result;
      m_data_be_o       <= md_done ? lat_be : data_be_i;
      m_load_op_o       <= md_done ? lat_load_op : load_op_i;
    end
  end

  // A stalled result must reach the memory stage unchanged
  a_hold_under_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> out_valid_o
      && $stable({m_regfile_waddr_o, m_rd_data_o, m_regfile_wr_o, m_data_addr_o,
                  m_data_wr_o, m_data_rd_o, m_data_be_o, m_load_op_o}));

endmodule

`default_nettype wire

// File: hdl/int_alu.sv
// Combinational RV32I arithmetic, logic, shift and compare unit
`default_nettype none
`timescale 1ns/100ps
`include "rv_exe_cfg.svh"

module int_alu
  import rv_exe_pkg::*;
(
  input  alu_op_e                op_i,
  input  wire [`DATA_WIDTH-1:0]  a_i,
  input  wire [`DATA_WIDTH-1:0]  b_i,
  output logic [`DATA_WIDTH-1:0] result_o
);

  logic [4:0] shamt;  // Only the low five bits count for RV32 shifts
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b_i[4:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb
  begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_OR:   result_o = a_i | b_i;
      ALU_AND:  result_o = a_i & b_i;
      // Set-less-than yields 0 or 1 in the low bit
      ALU_SLT:  result_o = {{(`DATA_WIDTH-1){1'b0}}, lt_signed};
      ALU_SLTU: result_o = {{(`DATA_WIDTH-1){1'b0}}, lt_unsigned};
      default:  result_o = '0;  // Undefined codes return zero
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/mul_div_unit.sv
// Iterative shift-add multiplier and restoring divider for the RV32M instructions
`default_nettype none
`timescale 1ns/100ps
`include "rv_exe_cfg.svh"

module mul_div_unit
  import rv_exe_pkg::*;
(
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    start_i,
  input  md_op_e                 op_i,
  input  wire [`DATA_WIDTH-1:0]  a_i,
  input  wire [`DATA_WIDTH-1:0]  b_i,
  output logic [`DATA_WIDTH-1:0] result_o,
  output logic                   busy_o,
  output logic                   done_o
);

  localparam int W     = `DATA_WIDTH;
  localparam int CNT_W = $clog2(`MD_ITERATIONS);

  md_state_e      state_q;
  logic [CNT_W-1:0] cnt_q;

  md_op_e         op_q;
  logic [W-1:0]   hi_q;    // Upper product half, or partial remainder
  logic [W-1:0]   lo_q;    // Multiplier shifting out, or quotient shifting in
  logic [W-1:0]   opnd_q;  // Multiplicand or divisor magnitude
  logic           res_neg_q;
  logic           a_neg_q;
  logic           div_zero_q;

  logic           a_signed, b_signed;
  logic           a_neg, b_neg;
  logic [W-1:0]   a_mag, b_mag;
  logic           is_div;
  logic [W:0]     mul_sum;
  logic [W:0]     div_shift;
  logic [W:0]     div_diff;
  logic [2*W-1:0] prod_fix;
  logic [W-1:0]   quo_fix;
  logic [W-1:0]   rem_fix;

  // MULHSU treats only the first operand as signed
  assign a_signed = (op_i == M_MULH) || (op_i == M_MULHSU) || (op_i == M_DIV) || (op_i == M_REM);
  assign b_signed = (op_i == M_MULH) || (op_i == M_DIV) || (op_i == M_REM);
  assign a_neg    = a_signed & a_i[W-1];
  assign b_neg    = b_signed & b_i[W-1];
  assign a_mag    = a_neg ? (~a_i + 1'b1) : a_i;
  assign b_mag    = b_neg ? (~b_i + 1'b1) : b_i;

  assign is_div    = op_q[2];
  assign mul_sum   = {1'b0, hi_q} + (lo_q[0] ? {1'b0, opnd_q} : '0);
  assign div_shift = {hi_q, lo_q[W-1]};
  assign div_diff  = div_shift - {1'b0, opnd_q};  // Top bit set means the trial failed

  assign prod_fix = res_neg_q ? (~{hi_q, lo_q} + 1'b1) : {hi_q, lo_q};
  // A zero divisor leaves all ones in the quotient whatever the signs
  assign quo_fix  = div_zero_q ? '1 : (res_neg_q ? (~lo_q + 1'b1) : lo_q);
  assign rem_fix  = a_neg_q ? (~hi_q + 1'b1) : hi_q;  // Remainder takes the dividend's sign

  assign busy_o = (state_q != MD_IDLE);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= MD_IDLE;
      cnt_q   <= '0;
      done_o  <= 1'b0;
    end
    else
    begin
      done_o <= 1'b0;
      case (state_q)
        MD_IDLE:
          if (start_i)
          begin
            state_q <= MD_RUN;
            cnt_q   <= '0;
          end
        MD_RUN:
        begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == CNT_W'(`MD_ITERATIONS - 1))
            state_q <= MD_DONE;
        end
        MD_DONE:
        begin
          done_o  <= 1'b1;   // Result register is loaded on the same edge
          state_q <= MD_IDLE;
        end
        default: state_q <= MD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == MD_IDLE && start_i)
    begin
      op_q       <= op_i;
      hi_q       <= '0;
      lo_q       <= op_i[2] ? a_mag : b_mag;
      opnd_q     <= op_i[2] ? b_mag : a_mag;
      res_neg_q  <= a_neg ^ b_neg;
      a_neg_q    <= a_neg;
      div_zero_q <= op_i[2] && (b_i == '0);
    end
    else if (state_q == MD_RUN)
    begin
      if (is_div)
      begin
        hi_q <= div_diff[W] ? div_shift[W-1:0] : div_diff[W-1:0];
        lo_q <= {lo_q[W-2:0], ~div_diff[W]};
      end
      else
      begin
        hi_q <= mul_sum[W:1];
        lo_q <= {mul_sum[0], lo_q[W-1:1]};
      end
    end
    else if (state_q == MD_DONE)
    begin
      case (op_q)
        M_MUL:                    result_o <= prod_fix[W-1:0];
        M_MULH, M_MULHSU, M_MULHU: result_o <= prod_fix[2*W-1:W];
        M_DIV, M_DIVU:            result_o <= quo_fix;
        default:                  result_o <= rem_fix;
      endcase
    end
  end

  // A second start while an operation runs would corrupt the shared registers
  a_no_start_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> !busy_o);

endmodule

`default_nettype wire

// File: hdl/rv_exe_cfg.svh
// Width and iteration-count macros for the RV32IM execute stage
`ifndef RV_EXE_CFG_SVH
`define RV_EXE_CFG_SVH

// Operand, result and address width of the integer datapath
`define DATA_WIDTH 32

// Index width of the destination register, x0..x31
`define REG_ADDR_WIDTH 5

// One byte-enable bit per byte lane of a data word
`define MEM_TRANSFER_WIDTH 4

// The iterative unit retires one quotient or multiplier bit per step
`define MD_ITERATIONS `DATA_WIDTH

`endif

// File: hdl/rv_exe_pkg.sv
// Package with the execute-stage opcode, store, load, target and mul/div state enums
`default_nettype none

package rv_exe_pkg;

  // Bit 4 set selects the M extension unit, the low three bits then equal funct3
  typedef enum logic [4:0] {
    OP_ADD    = 5'b0_0000,
    OP_SLL    = 5'b0_0001,
    OP_SLT    = 5'b0_0010,
    OP_SLTU   = 5'b0_0011,
    OP_XOR    = 5'b0_0100,
    OP_SRL    = 5'b0_0101,
    OP_OR     = 5'b0_0110,
    OP_AND    = 5'b0_0111,
    OP_SUB    = 5'b0_1000,
    OP_SRA    = 5'b0_1101,
    OP_MUL    = 5'b1_0000,
    OP_MULH   = 5'b1_0001,
    OP_MULHSU = 5'b1_0010,
    OP_MULHU  = 5'b1_0011,
    OP_DIV    = 5'b1_0100,
    OP_DIVU   = 5'b1_0101,
    OP_REM    = 5'b1_0110,
    OP_REMU   = 5'b1_0111
  } exe_op_e;

  // Low four bits of exe_op_e, funct7[5] in bit 3 and funct3 below it
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  typedef enum logic [2:0] {
    M_MUL    = 3'b000,
    M_MULH   = 3'b001,
    M_MULHSU = 3'b010,
    M_MULHU  = 3'b011,
    M_DIV    = 3'b100,
    M_DIVU   = 3'b101,
    M_REM    = 3'b110,
    M_REMU   = 3'b111
  } md_op_e;

  typedef enum logic [1:0] {ST_NONE, ST_SB, ST_SH, ST_SW} store_op_e;

  // RV32 load funct3 codes, carried to the memory stage untouched
  typedef enum logic [2:0] {
    LD_LB  = 3'b000,
    LD_LH  = 3'b001,
    LD_LW  = 3'b010,
    LD_LBU = 3'b100,
    LD_LHU = 3'b101
  } load_op_e;

  typedef enum logic [1:0] {TGT_ALU, TGT_STORE, TGT_ZERO, TGT_LINK} target_e;

  typedef enum logic [1:0] {MD_IDLE, MD_RUN, MD_DONE} md_state_e;

endpackage

`default_nettype wire

// File: tb.f
+incdir+hdl
hdl/rv_exe_pkg.sv
hdl/int_alu.sv
hdl/mul_div_unit.sv
hdl/exe_stage.sv
tb/exe_stage_tb.sv

// File: tb/exe_stage_tb.sv
// Testbench for the RV32IM execute stage, driven from a trace file under random back-pressure
`default_nettype none
`timescale 1ns/100ps
`include "rv_exe_cfg.svh"

module exe_stage_tb
  import rv_exe_pkg::*;
();

  localparam int ACCEPT_TIMEOUT = 400;
  localparam int DRAIN_TIMEOUT  = 400;
  localparam int MD_LATENCY     = `MD_ITERATIONS + 2;

  typedef struct packed {
    logic [`REG_ADDR_WIDTH-1:0]     waddr;
    logic [`DATA_WIDTH-1:0]         rd_data;
    logic [`DATA_WIDTH-1:0]         addr;
    logic                           rf_wr;
    logic                           data_wr;
    logic                           data_rd;
    logic [`MEM_TRANSFER_WIDTH-1:0] be;
    load_op_e                       load_op;
  } expect_t;

  logic clk, rst_n, in_valid_i, in_ready_o, use_imm_i, link_pc4_i;
  exe_op_e op_i;
  logic [`DATA_WIDTH-1:0] rs1_i, rs2_i, imm_i, pc4_i, brj_pc_i;
  store_op_e store_op_i;
  load_op_e  load_op_i;
  target_e   target_i;
  logic [`REG_ADDR_WIDTH-1:0] waddr_i;
  logic regfile_wr_i, data_wr_i, data_rd_i;
  logic [`MEM_TRANSFER_WIDTH-1:0] data_be_i;
  logic out_valid_o, out_ready_i, m_regfile_wr_o, m_data_wr_o, m_data_rd_o;
  logic [`REG_ADDR_WIDTH-1:0] m_regfile_waddr_o;
  logic [`DATA_WIDTH-1:0] m_rd_data_o, m_data_addr_o;
  logic [`MEM_TRANSFER_WIDTH-1:0] m_data_be_o;
  load_op_e m_load_op_o;

  expect_t exp_q[$];  // One entry per driven trace line, oldest first
  logic [`DATA_WIDTH-1:0] fld [0:17];
  int lines_driven = 0;
  int outputs_seen = 0;

  exe_stage dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Memory-side ready, one LFSR bit per cycle
  initial
  begin : ready_gen
    logic [15:0] lfsr;
    lfsr = 16'd85;
    out_ready_i = 1'b0;
    forever
    begin
      @(posedge clk);
      out_ready_i <= lfsr[0];
      lfsr = lfsr_step(lfsr);
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [`DATA_WIDTH-1:0] got,
                            input logic [`DATA_WIDTH-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_addr(input string name, input logic [`REG_ADDR_WIDTH-1:0] got,
                            input logic [`REG_ADDR_WIDTH-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_be(input string name, input logic [`MEM_TRANSFER_WIDTH-1:0] got,
                          input logic [`MEM_TRANSFER_WIDTH-1:0] exp);
    if (got !== exp)
      abort_run($sformatf("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("ERROR t=%0t %s: got %b expected %b", $time, name, got, exp));
  endtask

  task automatic check_load(input string name, input load_op_e got, input load_op_e exp);
    if (got !== exp)
      abort_run($sformatf("ERROR t=%0t %s: got %h expected %h", $time, name, got, exp));
  endtask

  task automatic compare_outputs(input expect_t e);
    check_addr("m_regfile_waddr_o", m_regfile_waddr_o, e.waddr);
    check_word("m_rd_data_o", m_rd_data_o, e.rd_data);
    check_word("m_data_addr_o", m_data_addr_o, e.addr);
    check_bit("m_regfile_wr_o", m_regfile_wr_o, e.rf_wr);
    check_bit("m_data_wr_o", m_data_wr_o, e.data_wr);
    check_bit("m_data_rd_o", m_data_rd_o, e.data_rd);
    check_be("m_data_be_o", m_data_be_o, e.be);
    check_load("m_load_op_o", m_load_op_o, e.load_op);
  endtask

  // Present one trace line and queue the outputs it must produce
  task automatic drive_instruction();
    expect_t e;
    op_i         <= exe_op_e'(fld[0][4:0]);
    use_imm_i    <= fld[1][0];
    link_pc4_i   <= fld[2][0];
    rs1_i        <= fld[3];
    rs2_i        <= fld[4];
    imm_i        <= fld[5];
    pc4_i        <= fld[6];
    brj_pc_i     <= fld[7];
    store_op_i   <= store_op_e'(fld[8][1:0]);
    load_op_i    <= load_op_e'(fld[9][2:0]);
    target_i     <= target_e'(fld[10][1:0]);
    waddr_i      <= fld[11][`REG_ADDR_WIDTH-1:0];
    regfile_wr_i <= fld[12][0];
    data_wr_i    <= fld[13][0];
    data_rd_i    <= fld[14][0];
    data_be_i    <= fld[15][`MEM_TRANSFER_WIDTH-1:0];
    in_valid_i   <= 1'b1;
    e.waddr   = fld[11][`REG_ADDR_WIDTH-1:0];
    e.rd_data = fld[16];
    e.addr    = fld[17];
    e.rf_wr   = fld[12][0];
    e.data_wr = fld[13][0];
    e.data_rd = fld[14][0];
    e.be      = fld[15][`MEM_TRANSFER_WIDTH-1:0];
    e.load_op = load_op_e'(fld[9][2:0]);
    exp_q.push_back(e);
    lines_driven++;
  endtask

  // Returns on the edge where the DUT takes the instruction
  task automatic wait_accept();
    int waited;
    waited = 0;
    @(posedge clk);
    while (!in_ready_o)
    begin
      waited++;
      if (waited > ACCEPT_TIMEOUT)
        abort_run("Timeout: the DUT never accepted the pending instruction");
      @(posedge clk);
    end
  endtask

  // Output monitor; all values are the ones settled before this edge
  always @(posedge clk)
  begin : monitor
    static int      cyc = 0;
    static int      acc_cyc = 0;
    static logic    md_pending = 1'b0;
    static logic    hold_pending = 1'b0;
    expect_t        e;
    if (rst_n)
    begin
      cyc++;
      if (hold_pending)
        check_bit("out_valid_o", out_valid_o, 1'b1);  // A stalled result may not vanish
      hold_pending = out_valid_o && !out_ready_i;
      if (md_pending)
      begin
        if (out_valid_o)
        begin
          if (cyc - 1 - acc_cyc != MD_LATENCY)
            abort_run($sformatf("Multiply/divide result came %0d cycles after acceptance",
                                cyc - 1 - acc_cyc));
          md_pending = 1'b0;
        end
        else if (in_ready_o)
          abort_run("in_ready_o went high while a multiply/divide was still running");
      end
      if (out_valid_o)
      begin
        if (exp_q.size() == 0)
          abort_run("The DUT presented a result that no instruction asked for");
        e = exp_q[0];
        compare_outputs(e);  // Every valid cycle counts, so a held result must not drift
        if (out_ready_i)
        begin
          void'(exp_q.pop_front());
          outputs_seen++;
        end
      end
      if (in_valid_i && in_ready_o && op_i[4])
      begin
        md_pending = 1'b1;
        acc_cyc    = cyc;
      end
    end
  end

  initial
  begin : driver
    int    fd;
    int    n;
    int    waited;
    string line;
    rst_n = 1'b0;
    in_valid_i = 1'b0;
    op_i = OP_ADD;
    use_imm_i = 1'b0;
    link_pc4_i = 1'b0;
    rs1_i = '0;
    rs2_i = '0;
    imm_i = '0;
    pc4_i = '0;
    brj_pc_i = '0;
    store_op_i = ST_NONE;
    load_op_i = LD_LW;
    target_i = TGT_ALU;
    waddr_i = '0;
    regfile_wr_i = 1'b0;
    data_wr_i = 1'b0;
    data_rd_i = 1'b0;
    data_be_i = '0;
    repeat (8) @(posedge clk);
    check_bit("out_valid_o", out_valid_o, 1'b0);
    check_bit("m_regfile_wr_o", m_regfile_wr_o, 1'b0);
    check_bit("m_data_wr_o", m_data_wr_o, 1'b0);
    check_bit("m_data_rd_o", m_data_rd_o, 1'b0);
    check_bit("in_ready_o", in_ready_o, 1'b1);
    rst_n <= 1'b1;
    @(posedge clk);
    check_bit("in_ready_o", in_ready_o, 1'b1);  // Still idle right after reset
    check_bit("out_valid_o", out_valid_o, 1'b0);
    fd = $fopen("tb/exe_trace.txt", "r");
    if (fd == 0)
      abort_run("Cannot open the trace file tb/exe_trace.txt");
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() < 8 || line.getc(0) == "#")
        continue;  // Blank or column-header line
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7], fld[8],
                  fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15], fld[16],
                  fld[17]);
      if (n != 18)
        abort_run($sformatf("Trace line has %0d fields instead of 18: %s", n, line));
      drive_instruction();
      wait_accept();
    end
    $fclose(fd);
    in_valid_i <= 1'b0;
    waited = 0;
    while (outputs_seen < lines_driven)
    begin
      waited++;
      if (waited > DRAIN_TIMEOUT)
        abort_run("Timeout: not every trace line produced an output");
      @(posedge clk);
    end
    repeat (8) @(posedge clk);  // Room for a stray extra output to show up
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/exe_trace.txt
# op use_imm link_pc4 rs1 rs2 imm pc4 brj_pc store_op load_op target waddr rf_wr data_wr data_rd be
# then the expected m_rd_data_o and m_data_addr_o, all fields in hex
00 0 0 00000007 00000003 00000000 00000104 00000200 0 2 0 01 1 0 0 0 0000000a 0000000a
00 1 0 00001000 deadbeef fffffff0 00000104 00000200 0 2 0 02 1 0 0 0 00000ff0 00000ff0
08 0 0 00000005 00000008 00000000 00000104 00000200 0 2 0 03 1 0 0 0 fffffffd fffffffd
01 1 0 00000001 00000000 00000024 00000104 00000200 0 2 0 04 1 0 0 0 00000010 00000010
02 0 0 ffffffff 00000001 00000000 00000104 00000200 0 2 0 05 1 0 0 0 00000001 00000001
03 0 0 ffffffff 00000001 00000000 00000104 00000200 0 2 0 06 1 0 0 0 00000000 00000000
04 0 0 f0f0f0f0 0ff00ff0 00000000 00000104 00000200 0 2 0 07 1 0 0 0 ff00ff00 ff00ff00
05 0 0 80000000 0000001f 00000000 00000104 00000200 0 2 0 08 1 0 0 0 00000001 00000001
0d 1 0 80000000 00000000 00000004 00000104 00000200 0 2 0 09 1 0 0 0 f8000000 f8000000
06 0 0 12340000 00005678 00000000 00000104 00000200 0 2 0 0a 1 0 0 0 12345678 12345678
07 1 0 12345678 00000000 0000ff00 00000104 00000200 0 2 0 0b 1 0 0 0 00005600 00005600
02 1 0 00000003 00000000 fffffffe 00000104 00000200 0 2 0 0c 1 0 0 0 00000000 00000000
10 0 0 00000007 fffffffd 00000000 00000104 00000200 0 2 0 0d 1 0 0 0 ffffffeb ffffffeb
11 0 0 80000000 80000000 00000000 00000104 00000200 0 2 0 0e 1 0 0 0 40000000 40000000
12 0 0 ffffffff ffffffff 00000000 00000104 00000200 0 2 0 0f 1 0 0 0 ffffffff ffffffff
13 0 0 ffffffff ffffffff 00000000 00000104 00000200 0 2 0 10 1 0 0 0 fffffffe fffffffe
14 0 0 ffffffec 00000006 00000000 00000104 00000200 0 2 0 11 1 0 0 0 fffffffd fffffffd
15 1 0 00000064 00000000 00000007 00000104 00000200 0 2 0 12 1 0 0 0 0000000e 0000000e
16 0 0 ffffffec 00000006 00000000 00000104 00000200 0 2 0 13 1 0 0 0 fffffffe fffffffe
17 0 0 00000064 00000007 00000000 00000104 00000200 0 2 0 14 1 0 0 0 00000002 00000002
14 0 0 00001234 00000000 00000000 00000104 00000200 0 2 0 15 1 0 0 0 ffffffff ffffffff
15 0 0 00000010 00000000 00000000 00000104 00000200 0 2 0 16 1 0 0 0 ffffffff ffffffff
16 0 0 ffffff85 00000000 00000000 00000104 00000200 0 2 0 17 1 0 0 0 ffffff85 ffffff85
17 0 0 80000000 00000000 00000000 00000104 00000200 0 2 3 18 1 0 0 0 00000200 80000000
14 0 0 80000000 ffffffff 00000000 00000104 00000200 0 2 0 19 1 0 0 0 80000000 80000000
16 0 0 80000000 ffffffff 00000000 00000104 00000200 0 2 0 1a 1 0 0 0 00000000 00000000
00 1 0 00002000 cafebabe 00000003 00000104 00000200 1 2 1 00 0 1 0 8 000000be 00002003
00 1 0 00002000 cafebabe 00000002 00000104 00000200 2 2 1 00 0 1 0 c 0000babe 00002002
00 1 0 00002000 cafebabe fffffffc 00000104 00000200 3 2 1 00 0 1 0 f cafebabe 00001ffc
00 1 0 00003000 00000000 00000001 00000104 00000200 0 4 0 1b 1 0 1 2 00003001 00003001
00 1 1 00000100 00000000 00000040 00000104 00000140 0 2 3 01 1 0 0 0 00000104 00000140
00 1 0 00000100 00000000 00000040 00000104 00000140 0 2 3 00 0 0 0 0 00000140 00000140
06 0 0 ffffffff 00000000 00000000 00000104 00000200 0 1 2 1f 1 0 0 0 00000000 ffffffff
